/* common/ibuf_mux_pkg.sv */
/*
  shared widths and client tag for the two-client input buffer
  a line is WORDS_PER_LINE memory words, word 0 in the low bits
  WORD_SEL_W must equal $clog2(WORDS_PER_LINE)
*/
package ibuf_mux_pkg;

  // one narrow word as written by a client
  localparam int MEM_DATA_W = 32;

  // words returned together on a read
  localparam int WORDS_PER_LINE = 2;

  // low word address bits that pick the lane inside a line
  localparam int WORD_SEL_W = 1;

  // full read line
  localparam int LINE_W = MEM_DATA_W * WORDS_PER_LINE;

  typedef logic [MEM_DATA_W-1:0] mem_word_t;

  // word n sits at [n*MEM_DATA_W +: MEM_DATA_W]
  typedef logic [LINE_W-1:0] line_t;

  // which client issued a request
  // lidar is the default side of the select, so it takes the zero code
  typedef enum logic [0:0] {
    CLIENT_LIDAR = 1'b0,
    CLIENT_MAIN  = 1'b1
  } client_e;

endpackage

/* hdl/port_select.sv */
/*
  request stage of the shared buffer
  choose_main picks one client; the other client's requests are dropped
  every accepted request is registered for exactly one cycle without back-pressure
*/
module port_select import ibuf_mux_pkg::*; #(
  parameter int LINE_ADDR_W = 6
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               choose_main,
  // main pipeline
  input  logic [LINE_ADDR_W+WORD_SEL_W-1:0]  main_wr_addr,
  input  logic                               main_wr_req,
  input  mem_word_t                          main_wr_data,
  input  logic [LINE_ADDR_W-1:0]             main_rd_addr,
  input  logic                               main_rd_req,
  // lidar pipeline
  input  logic [LINE_ADDR_W+WORD_SEL_W-1:0]  lidar_wr_addr,
  input  logic                               lidar_wr_req,
  input  mem_word_t                          lidar_wr_data,
  input  logic [LINE_ADDR_W-1:0]             lidar_rd_addr,
  input  logic                               lidar_rd_req,
  // registered requests toward the buffer
  output logic                               wr_req_q,
  output logic [LINE_ADDR_W+WORD_SEL_W-1:0]  wr_addr_q,
  output mem_word_t                          wr_data_q,
  output logic                               rd_req_q,
  output logic [LINE_ADDR_W-1:0]             rd_addr_q,
  output client_e                            rd_client_q
);

  localparam int WORD_ADDR_W = LINE_ADDR_W + WORD_SEL_W;

  logic                   sel_wr_req;
  logic [WORD_ADDR_W-1:0] sel_wr_addr;
  mem_word_t              sel_wr_data;
  logic                   sel_rd_req;
  logic [LINE_ADDR_W-1:0] sel_rd_addr;
  client_e                sel_client;

  // plain 2:1 select on the level
  assign sel_wr_req  = choose_main ? main_wr_req  : lidar_wr_req;
  assign sel_wr_addr = choose_main ? main_wr_addr : lidar_wr_addr;
  assign sel_wr_data = choose_main ? main_wr_data : lidar_wr_data;
  assign sel_rd_req  = choose_main ? main_rd_req  : lidar_rd_req;
  assign sel_rd_addr = choose_main ? main_rd_addr : lidar_rd_addr;
  assign sel_client  = choose_main ? CLIENT_MAIN  : CLIENT_LIDAR;

  // strobes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_req_q <= 1'b0;
      rd_req_q <= 1'b0;
    end else begin
      wr_req_q <= sel_wr_req;
      rd_req_q <= sel_rd_req;
    end
  end

  // write payload only moves with a write
  always_ff @(posedge clk) begin
    if (sel_wr_req) begin
      wr_addr_q <= sel_wr_addr;
      wr_data_q <= sel_wr_data;
    end
  end

  // read address and owner tag frozen when the read is sampled
  always_ff @(posedge clk) begin
    if (sel_rd_req) begin
      rd_addr_q   <= sel_rd_addr;
      rd_client_q <= sel_client;
    end
  end

  // downstream counts on clean strobes once out of reset
  a_req_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown({rd_req_q, wr_req_q})
  ) else $error("port_select request strobe unknown");

endmodule

/* line_buffer/line_buffer.sv */
/*
  shared line buffer, word writes and whole-line reads
  read is synchronous and read-first: a same-edge write to the line is not seen
  storage has no reset, unwritten lines read back undefined
*/
module line_buffer import ibuf_mux_pkg::*; #(
  parameter int LINE_ADDR_W = 6
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // word write port
  input  logic                               wr_req,
  input  logic [LINE_ADDR_W+WORD_SEL_W-1:0]  wr_addr,
  input  mem_word_t                          wr_data,
  // line read port
  input  logic                               rd_req,
  input  logic [LINE_ADDR_W-1:0]             rd_addr,
  input  client_e                            rd_client,
  // read result, one cycle after rd_req
  output line_t                              rd_line,
  output logic                               rd_strobe,
  output client_e                            rd_client_out
);

  localparam int WORD_ADDR_W = LINE_ADDR_W + WORD_SEL_W;
  localparam int LINE_COUNT  = 2 ** LINE_ADDR_W;

  logic [LINE_ADDR_W-1:0] wr_line;
  logic [WORD_SEL_W-1:0]  wr_lane;

  // upper bits pick the line, low bits the lane
  assign wr_line = wr_addr[WORD_ADDR_W-1:WORD_SEL_W];
  assign wr_lane = wr_addr[WORD_SEL_W-1:0];

  // one narrow RAM per lane
  // each lane writes only when addressed, all lanes read together
  for (genvar g = 0; g < WORDS_PER_LINE; g++) begin : g_lane
    mem_word_t lane_mem [LINE_COUNT];

    always_ff @(posedge clk) begin
      if (wr_req && (wr_lane == WORD_SEL_W'(g))) begin
        lane_mem[wr_line] <= wr_data;
      end
    end

    // nonblocking read of the array gives old data on a collision
    always_ff @(posedge clk) begin
      if (rd_req) begin
        rd_line[g*MEM_DATA_W +: MEM_DATA_W] <= lane_mem[rd_addr];
      end
    end
  end

  // strobe marks the cycle rd_line is fresh
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_strobe <= 1'b0;
    end else begin
      rd_strobe <= rd_req;
    end
  end

  // owner rides alongside the data
  always_ff @(posedge clk) begin
    if (rd_req) begin
      rd_client_out <= rd_client;
    end
  end

  // an X address would hit an unknown line, data silently lost
  a_wr_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_req |-> !$isunknown(wr_addr)
  ) else $error("line_buffer write address unknown with wr_req high");

  a_rd_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_req |-> !$isunknown({rd_addr, rd_client})
  ) else $error("line_buffer read address or tag unknown with rd_req high");

endmodule

/* hdl/read_return.sv */
/*
  read return stage
  read_data goes to both clients while the valid pulse names the owner
  read_data has no reset and only changes when a line comes back
*/
module read_return import ibuf_mux_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  line_t   rd_line,
  input  logic    rd_strobe,
  input  client_e rd_client,
  output line_t   read_data,
  output logic    main_read_valid,
  output logic    lidar_read_valid
);

  // hold the line until the next return
  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      read_data <= rd_line;
    end
  end

  // decode tag into per-client pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      main_read_valid  <= 1'b0;
      lidar_read_valid <= 1'b0;
    end else begin
      main_read_valid  <= rd_strobe && (rd_client == CLIENT_MAIN);
      lidar_read_valid <= rd_strobe && (rd_client == CLIENT_LIDAR);
    end
  end

  // one owner per returned line
  a_one_owner: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(main_read_valid && lidar_read_valid)
  ) else $error("read_return both client valids high");

endmodule

/* hdl/ibuf_ram_mux.sv */
/*
  two-client input buffer, main and lidar share one RAM
  choose_main high selects main, low selects lidar; no back-pressure
  read latency is three cycles from sampling to the owner's valid pulse
*/
module ibuf_ram_mux import ibuf_mux_pkg::*; #(
  parameter int LINE_ADDR_W = 6
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               choose_main,
  // main pipeline
  input  logic [LINE_ADDR_W+WORD_SEL_W-1:0]  main_wr_addr,
  input  logic                               main_wr_req,
  input  mem_word_t                          main_wr_data,
  input  logic [LINE_ADDR_W-1:0]             main_rd_addr,
  input  logic                               main_rd_req,
  // lidar pipeline
  input  logic [LINE_ADDR_W+WORD_SEL_W-1:0]  lidar_wr_addr,
  input  logic                               lidar_wr_req,
  input  mem_word_t                          lidar_wr_data,
  input  logic [LINE_ADDR_W-1:0]             lidar_rd_addr,
  input  logic                               lidar_rd_req,
  // shared return
  output line_t                              read_data,
  output logic                               main_read_valid,
  output logic                               lidar_read_valid
);

  localparam int WORD_ADDR_W = LINE_ADDR_W + WORD_SEL_W;

  // request stage to buffer
  logic                   wr_req_q;
  logic [WORD_ADDR_W-1:0] wr_addr_q;
  mem_word_t              wr_data_q;
  logic                   rd_req_q;
  logic [LINE_ADDR_W-1:0] rd_addr_q;
  client_e                rd_client_q;

  // buffer to return stage
  line_t                  buf_rd_line;
  logic                   buf_rd_strobe;
  client_e                buf_rd_client;

  port_select #(
    .LINE_ADDR_W (LINE_ADDR_W)
  ) u_port_select (
    .clk           (clk),
    .rst_n         (rst_n),
    .choose_main   (choose_main),
    .main_wr_addr  (main_wr_addr),
    .main_wr_req   (main_wr_req),
    .main_wr_data  (main_wr_data),
    .main_rd_addr  (main_rd_addr),
    .main_rd_req   (main_rd_req),
    .lidar_wr_addr (lidar_wr_addr),
    .lidar_wr_req  (lidar_wr_req),
    .lidar_wr_data (lidar_wr_data),
    .lidar_rd_addr (lidar_rd_addr),
    .lidar_rd_req  (lidar_rd_req),
    .wr_req_q      (wr_req_q),
    .wr_addr_q     (wr_addr_q),
    .wr_data_q     (wr_data_q),
    .rd_req_q      (rd_req_q),
    .rd_addr_q     (rd_addr_q),
    .rd_client_q   (rd_client_q)
  );

  line_buffer #(
    .LINE_ADDR_W (LINE_ADDR_W)
  ) u_line_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_req        (wr_req_q),
    .wr_addr       (wr_addr_q),
    .wr_data       (wr_data_q),
    .rd_req        (rd_req_q),
    .rd_addr       (rd_addr_q),
    .rd_client     (rd_client_q),
    .rd_line       (buf_rd_line),
    .rd_strobe     (buf_rd_strobe),
    .rd_client_out (buf_rd_client)
  );

  read_return u_read_return (
    .clk              (clk),
    .rst_n            (rst_n),
    .rd_line          (buf_rd_line),
    .rd_strobe        (buf_rd_strobe),
    .rd_client        (buf_rd_client),
    .read_data        (read_data),
    .main_read_valid  (main_read_valid),
    .lidar_read_valid (lidar_read_valid)
  );

endmodule

/* test/tb_ibuf_ram_mux.sv */
/*
  testbench for the two-client input buffer, default LINE_ADDR_W only
  a line model tracks the selected writes, each issued read queues its expected line
  only lines that were fully written are read back
*/
module tb_ibuf_ram_mux import ibuf_mux_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LINE_ADDR_W = 6;
  localparam int WORD_ADDR_W = LINE_ADDR_W + WORD_SEL_W;
  localparam int LINE_COUNT  = 2 ** LINE_ADDR_W;
  localparam int CLK_HALF_NS = 50;

  // stimulus length per test, drains included
  localparam int IDLE_OPS   = 5;
  localparam int MAIN_OPS   = 16 + 8;
  localparam int LIDAR_OPS  = 16 + 12;
  localparam int SHARE_OPS  = 8 + 8;
  localparam int B2B_OPS    = 16 + 4;
  localparam int DRAIN_MAX  = 8;
  localparam int N_DRAINS   = 5;
  localparam int N_OPS      = IDLE_OPS + MAIN_OPS + LIDAR_OPS + SHARE_OPS + B2B_OPS
                              + DRAIN_MAX * N_DRAINS;
  localparam int WATCHDOG_NS = (N_OPS + 20) * 100 * 2;

  logic                   clk;
  logic                   rst_n;
  logic                   choose_main;
  logic [WORD_ADDR_W-1:0] main_wr_addr;
  logic                   main_wr_req;
  mem_word_t              main_wr_data;
  logic [LINE_ADDR_W-1:0] main_rd_addr;
  logic                   main_rd_req;
  logic [WORD_ADDR_W-1:0] lidar_wr_addr;
  logic                   lidar_wr_req;
  mem_word_t              lidar_wr_data;
  logic [LINE_ADDR_W-1:0] lidar_rd_addr;
  logic                   lidar_rd_req;
  line_t                  read_data;
  logic                   main_read_valid;
  logic                   lidar_read_valid;

  // values for the next edge, applied by step()
  logic                   nxt_choose_main;
  logic [WORD_ADDR_W-1:0] nxt_main_wr_addr;
  logic                   nxt_main_wr_req;
  mem_word_t              nxt_main_wr_data;
  logic [LINE_ADDR_W-1:0] nxt_main_rd_addr;
  logic                   nxt_main_rd_req;
  logic [WORD_ADDR_W-1:0] nxt_lidar_wr_addr;
  logic                   nxt_lidar_wr_req;
  mem_word_t              nxt_lidar_wr_data;
  logic [LINE_ADDR_W-1:0] nxt_lidar_rd_addr;
  logic                   nxt_lidar_rd_req;

  // reference model and expected returns, oldest first
  line_t      model_mem [LINE_COUNT];
  line_t      exp_line [$];
  client_e    exp_client [$];
  int         exp_due [$];

  logic [31:0] lcg_state = 32'h9d47;
  int          cycle_cnt = 0;
  logic        read_issued = 1'b0;
  int          value_errors = 0;
  int          proto_errors = 0;

  ibuf_ram_mux i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .choose_main      (choose_main),
    .main_wr_addr     (main_wr_addr),
    .main_wr_req      (main_wr_req),
    .main_wr_data     (main_wr_data),
    .main_rd_addr     (main_rd_addr),
    .main_rd_req      (main_rd_req),
    .lidar_wr_addr    (lidar_wr_addr),
    .lidar_wr_req     (lidar_wr_req),
    .lidar_wr_data    (lidar_wr_data),
    .lidar_rd_addr    (lidar_rd_addr),
    .lidar_rd_req     (lidar_rd_req),
    .read_data        (read_data),
    .main_read_valid  (main_read_valid),
    .lidar_read_valid (lidar_read_valid)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF_NS clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // strobes back to idle, payload left as is
  task automatic clear_strobes();
    nxt_main_wr_req  = 1'b0;
    nxt_main_rd_req  = 1'b0;
    nxt_lidar_wr_req = 1'b0;
    nxt_lidar_rd_req = 1'b0;
  endtask

  task automatic stage_write(input client_e c, input int line, input int lane,
                             input mem_word_t data);
    logic [WORD_ADDR_W-1:0] addr;
    addr = {LINE_ADDR_W'(line), WORD_SEL_W'(lane)};
    if (c == CLIENT_MAIN) begin
      nxt_main_wr_req  = 1'b1;
      nxt_main_wr_addr = addr;
      nxt_main_wr_data = data;
    end else begin
      nxt_lidar_wr_req  = 1'b1;
      nxt_lidar_wr_addr = addr;
      nxt_lidar_wr_data = data;
    end
  endtask

  task automatic stage_read(input client_e c, input int line);
    if (c == CLIENT_MAIN) begin
      nxt_main_rd_req  = 1'b1;
      nxt_main_rd_addr = LINE_ADDR_W'(line);
    end else begin
      nxt_lidar_rd_req  = 1'b1;
      nxt_lidar_rd_addr = LINE_ADDR_W'(line);
    end
  endtask

  // random requests on the main side, meant to be ignored
  task automatic stage_main_noise();
    logic [31:0] r;
    r = next_rand();
    nxt_main_wr_req  = r[0];
    nxt_main_rd_req  = r[1];
    nxt_main_wr_addr = r[8 +: WORD_ADDR_W];
    nxt_main_rd_addr = r[16 +: LINE_ADDR_W];
    nxt_main_wr_data = next_rand();
  endtask

  // one edge: drive staged inputs, then update the model
  task automatic step();
    logic                   s_wr;
    logic [WORD_ADDR_W-1:0] s_wa;
    mem_word_t              s_wd;
    logic                   s_rd;
    logic [LINE_ADDR_W-1:0] s_ra;
    int                     lane;
    @(posedge clk);
    choose_main   <= nxt_choose_main;
    main_wr_addr  <= nxt_main_wr_addr;
    main_wr_req   <= nxt_main_wr_req;
    main_wr_data  <= nxt_main_wr_data;
    main_rd_addr  <= nxt_main_rd_addr;
    main_rd_req   <= nxt_main_rd_req;
    lidar_wr_addr <= nxt_lidar_wr_addr;
    lidar_wr_req  <= nxt_lidar_wr_req;
    lidar_wr_data <= nxt_lidar_wr_data;
    lidar_rd_addr <= nxt_lidar_rd_addr;
    lidar_rd_req  <= nxt_lidar_rd_req;
    s_wr = nxt_choose_main ? nxt_main_wr_req  : nxt_lidar_wr_req;
    s_wa = nxt_choose_main ? nxt_main_wr_addr : nxt_lidar_wr_addr;
    s_wd = nxt_choose_main ? nxt_main_wr_data : nxt_lidar_wr_data;
    s_rd = nxt_choose_main ? nxt_main_rd_req  : nxt_lidar_rd_req;
    s_ra = nxt_choose_main ? nxt_main_rd_addr : nxt_lidar_rd_addr;
    // read before write, so a same-cycle write to the line is not seen
    if (s_rd) begin
      exp_line.push_back(model_mem[s_ra]);
      exp_client.push_back(nxt_choose_main ? CLIENT_MAIN : CLIENT_LIDAR);
      // cycle_cnt still holds the count from before this edge
      exp_due.push_back(cycle_cnt + 4);
      read_issued = 1'b1;
    end
    if (s_wr) begin
      lane = int'(s_wa[WORD_SEL_W-1:0]);
      model_mem[s_wa[WORD_ADDR_W-1:WORD_SEL_W]][lane*MEM_DATA_W +: MEM_DATA_W] = s_wd;
    end
    clear_strobes();
  endtask

  // idle until all expected lines came back, bounded
  task automatic drain();
    int guard;
    guard = 0;
    while (exp_line.size() > 0 && guard < DRAIN_MAX) begin
      step();
      guard++;
    end
    if (exp_line.size() > 0) begin
      proto_errors++;
      $display("%0t: %0d reads never returned", $time, exp_line.size());
    end
  endtask

  // valid pulses checked mid-cycle against the expected queue
  always @(negedge clk) begin
    if (rst_n) begin
      if (main_read_valid || lidar_read_valid) begin
        if (exp_line.size() == 0) begin
          proto_errors++;
          $display("%0t: read valid pulse with no read outstanding", $time);
        end else begin
          if (exp_due[0] != cycle_cnt) begin
            proto_errors++;
            $display("%0t: valid pulse in cycle %0d, expected in cycle %0d",
                     $time, cycle_cnt, exp_due[0]);
          end
          if (main_read_valid !== (exp_client[0] == CLIENT_MAIN)) begin
            value_errors++;
            $display("error at %0t: main_read_valid expected %b actual %b", $time,
                     exp_client[0] == CLIENT_MAIN, main_read_valid);
          end
          if (lidar_read_valid !== (exp_client[0] == CLIENT_LIDAR)) begin
            value_errors++;
            $display("error at %0t: lidar_read_valid expected %b actual %b", $time,
                     exp_client[0] == CLIENT_LIDAR, lidar_read_valid);
          end
          if (read_data !== exp_line[0]) begin
            value_errors++;
            $display("error at %0t: read_data expected %h actual %h", $time,
                     exp_line[0], read_data);
          end
          void'(exp_line.pop_front());
          void'(exp_client.pop_front());
          void'(exp_due.pop_front());
        end
      end else if (exp_line.size() > 0 && exp_due[0] <= cycle_cnt) begin
        proto_errors++;
        $display("%0t: read due in cycle %0d returned no valid pulse", $time, exp_due[0]);
        void'(exp_line.pop_front());
        void'(exp_client.pop_front());
        void'(exp_due.pop_front());
      end
    end
  end

  a_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown({main_read_valid, lidar_read_valid})
  ) else begin
    proto_errors++;
    $display("%0t: a read valid is unknown after reset", $time);
  end

  a_valid_one_hot: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(main_read_valid && lidar_read_valid)
  ) else begin
    proto_errors++;
    $display("%0t: both read valids high in one cycle", $time);
  end

  // quiet outputs until the first read goes out
  a_quiet_before_read: assert property (
    @(posedge clk) disable iff (!rst_n)
    !read_issued |-> !(main_read_valid || lidar_read_valid)
  ) else begin
    proto_errors++;
    $display("%0t: read valid raised before any read was issued", $time);
  end

  a_data_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    (main_read_valid || lidar_read_valid) |-> !$isunknown(read_data)
  ) else begin
    proto_errors++;
    $display("%0t: read_data unknown during a valid pulse", $time);
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, stimulus did not finish", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

  initial begin
    for (int i = 0; i < LINE_COUNT; i++) begin
      model_mem[i] = 'x;
    end
    rst_n         = 1'b0;
    choose_main   = 1'b0;
    main_wr_addr  = '0;
    main_wr_req   = 1'b0;
    main_wr_data  = '0;
    main_rd_addr  = '0;
    main_rd_req   = 1'b0;
    lidar_wr_addr = '0;
    lidar_wr_req  = 1'b0;
    lidar_wr_data = '0;
    lidar_rd_addr = '0;
    lidar_rd_req  = 1'b0;
    nxt_choose_main   = 1'b0;
    nxt_main_wr_addr  = '0;
    nxt_main_wr_data  = '0;
    nxt_main_rd_addr  = '0;
    nxt_lidar_wr_addr = '0;
    nxt_lidar_wr_data = '0;
    nxt_lidar_rd_addr = '0;
    clear_strobes();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // idle after reset, valids must stay low
    repeat (IDLE_OPS) step();

    // main writes lines 0..7 then reads them back
    nxt_choose_main = 1'b1;
    for (int i = 0; i < 16; i++) begin
      stage_write(CLIENT_MAIN, i / 2, i % 2, next_rand());
      step();
    end
    for (int i = 0; i < 8; i++) begin
      stage_read(CLIENT_MAIN, i);
      step();
    end
    drain();

    // lidar selected, main side gets noise that must be dropped
    nxt_choose_main = 1'b0;
    for (int i = 0; i < 16; i++) begin
      stage_main_noise();
      stage_write(CLIENT_LIDAR, 8 + i / 2, i % 2, next_rand());
      step();
    end
    for (int i = 0; i < 12; i++) begin
      stage_main_noise();
      stage_read(CLIENT_LIDAR, (i < 8) ? 8 + i : i - 8);
      step();
    end
    drain();

    // shared storage seen from the other side
    nxt_choose_main = 1'b1;
    for (int i = 0; i < 8; i++) begin
      stage_read(CLIENT_MAIN, 8 + i);
      step();
    end
    nxt_choose_main = 1'b0;
    for (int i = 0; i < 8; i++) begin
      stage_read(CLIENT_LIDAR, i);
      step();
    end
    drain();

    // back-to-back reads, select toggling each cycle
    // the unselected client also asks for a different line
    for (int i = 0; i < 16; i++) begin
      nxt_choose_main = i[0];
      stage_read(CLIENT_MAIN, i);
      stage_read(CLIENT_LIDAR, 15 - i);
      step();
    end
    drain();

    // same-line collisions, old data first then new
    nxt_choose_main = 1'b1;
    stage_write(CLIENT_MAIN, 3, 0, next_rand());
    stage_read(CLIENT_MAIN, 3);
    step();
    stage_read(CLIENT_MAIN, 3);
    step();
    nxt_choose_main = 1'b0;
    stage_write(CLIENT_LIDAR, 10, 1, next_rand());
    stage_read(CLIENT_LIDAR, 10);
    step();
    stage_read(CLIENT_LIDAR, 10);
    step();
    drain();

    $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
    if (value_errors + proto_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* ibuf_ram_mux.f */
common/ibuf_mux_pkg.sv
hdl/port_select.sv
line_buffer/line_buffer.sv
hdl/read_return.sv
hdl/ibuf_ram_mux.sv
test/tb_ibuf_ram_mux.sv

/* Bender.yml */
package:
  name: ibuf_ram_mux

sources:
  # package first, then blocks, then the top level
  - files:
      - common/ibuf_mux_pkg.sv
      - hdl/port_select.sv
      - line_buffer/line_buffer.sv
      - hdl/read_return.sv
      - hdl/ibuf_ram_mux.sv

  - target: test
    files:
      - test/tb_ibuf_ram_mux.sv
